// File: ctlbridge.f
+incdir+.
ctlbridge_pkg.sv
ctlRegisterRam.sv
settingsSequencer.sv
settingsRegisters.sv
ctlBridge.sv
tbCtlBridge.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simCtlBridge

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f ctlbridge.f --top-module tbCtlBridge -o "$BIN"
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "run.sh: simulation reported failures"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "run.sh: simulation ended without a result"
    exit 1
fi

echo "run.sh: simulation passed"
exit 0

// File: tbCtlBridge.sv
`timescale 1ns/1ps
`include "ctlbridge_defines.svh"

module tbCtlBridge;
    import ctlbridge_pkg::*;

    localparam int ModIters = 4;
    localparam int SilencerIters = 4;
    localparam int BothIters = 2;
    localparam int StateIters = 4;
    localparam int GroupBound = 400;
    localparam int PollLimit = 50;
    localparam int ModWords = 11;
    localparam int SilencerWords = 5;
    // Fan test and reset test count as two iterations each.
    localparam int WatchdogCycles =
        (ModIters + SilencerIters + 2 * BothIters + StateIters + 4) * GroupBound;

    localparam regAddr_t ModAddrs [ModWords] = '{
        `AddrModReqRdSegment, `AddrModCycle0, `AddrModFreqDiv0Lo, `AddrModFreqDiv0Hi,
        `AddrModCycle1, `AddrModFreqDiv1Lo, `AddrModFreqDiv1Hi, `AddrModRep0Lo,
        `AddrModRep0Hi, `AddrModRep1Lo, `AddrModRep1Hi
    };
    localparam regAddr_t SilencerAddrs [SilencerWords] = '{
        `AddrSilencerMode, `AddrSilencerUpdateRateIntensity, `AddrSilencerUpdateRatePhase,
        `AddrSilencerCompletionStepsIntensity, `AddrSilencerCompletionStepsPhase
    };

    logic      CLK;
    logic      reset;
    logic      hostWe;
    regAddr_t  hostAddr;
    regWord_t  hostDin;
    regWord_t  hostDout;
    logic      thermo;
    logic      modSegment;
    logic      modUpdate;
    logic      modReqRdSegment;
    modCycle_t modCycle0;
    modCycle_t modCycle1;
    longWord_t modFreqDiv0;
    longWord_t modFreqDiv1;
    longWord_t modRep0;
    longWord_t modRep1;
    logic      silencerUpdate;
    logic      silencerMode;
    regWord_t  silencerUpdateRateIntensity;
    regWord_t  silencerUpdateRatePhase;
    regWord_t  silencerCompletionStepsIntensity;
    regWord_t  silencerCompletionStepsPhase;
    logic      forceFan;

    // Expected RAM contents as seen by the host.
    regWord_t    modelRam [2**`CtlAddrWidth];
    logic [15:0] lfsrState = 16'd90;
    int          errorCount = 0;
    int          checkCount = 0;
    int          modPulses = 0;
    int          silencerPulses = 0;
    int          pulseOrder = 0;
    int          modOrder = 0;
    int          silencerOrder = 0;

    ctlBridge i_ctlBridge (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge CLK);
        $display("watchdog timeout after %0d cycles, tests did not finish", WatchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    // Pulse counter that also remembers which group pulsed last.
    always @(posedge CLK) begin
        if (!reset && modUpdate) begin
            modPulses = modPulses + 1;
            pulseOrder = pulseOrder + 1;
            modOrder = pulseOrder;
        end
        if (!reset && silencerUpdate) begin
            silencerPulses = silencerPulses + 1;
            pulseOrder = pulseOrder + 1;
            silencerOrder = pulseOrder;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic nextLfsrBit();
        logic feedback;
        feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic regWord_t randomWord();
        regWord_t value;
        value = '0;
        for (int i = 0; i < 16; i++) begin
            value = {value[14:0], nextLfsrBit()};
        end
        return value;
    endfunction

    task automatic checkEqual(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic hostWrite(input regAddr_t addr, input regWord_t data);
        @(negedge CLK);
        hostWe = 1'b1;
        hostAddr = addr;
        hostDin = data;
        modelRam[addr] = data;
        @(negedge CLK);
        hostWe = 1'b0;
    endtask

    task automatic hostRead(input regAddr_t addr, output regWord_t data);
        @(negedge CLK);
        hostWe = 1'b0;
        hostAddr = addr;
        repeat (`RamReadLatency) @(posedge CLK);
        @(negedge CLK);
        data = hostDout;
    endtask

    task automatic writeGroupWords(input settingsGroup_t group);
        if (group == GroupMod) begin
            for (int i = 0; i < ModWords; i++) begin
                hostWrite(ModAddrs[i], randomWord());
            end
        end else begin
            for (int i = 0; i < SilencerWords; i++) begin
                hostWrite(SilencerAddrs[i], randomWord());
            end
        end
    endtask

    task automatic checkModOutputs(input string testName);
        checkEqual({testName, " reqRdSegment"}, 32'(modelRam[`AddrModReqRdSegment][0]),
                   32'(modReqRdSegment));
        checkEqual({testName, " cycle0"}, 32'(modelRam[`AddrModCycle0][14:0]), 32'(modCycle0));
        checkEqual({testName, " cycle1"}, 32'(modelRam[`AddrModCycle1][14:0]), 32'(modCycle1));
        checkEqual({testName, " freqDiv0"},
                   {modelRam[`AddrModFreqDiv0Hi], modelRam[`AddrModFreqDiv0Lo]}, modFreqDiv0);
        checkEqual({testName, " freqDiv1"},
                   {modelRam[`AddrModFreqDiv1Hi], modelRam[`AddrModFreqDiv1Lo]}, modFreqDiv1);
        checkEqual({testName, " rep0"}, {modelRam[`AddrModRep0Hi], modelRam[`AddrModRep0Lo]},
                   modRep0);
        checkEqual({testName, " rep1"}, {modelRam[`AddrModRep1Hi], modelRam[`AddrModRep1Lo]},
                   modRep1);
    endtask

    task automatic checkSilencerOutputs(input string testName);
        checkEqual({testName, " mode"}, 32'(modelRam[`AddrSilencerMode][0]), 32'(silencerMode));
        checkEqual({testName, " rateIntensity"},
                   32'(modelRam[`AddrSilencerUpdateRateIntensity]),
                   32'(silencerUpdateRateIntensity));
        checkEqual({testName, " ratePhase"}, 32'(modelRam[`AddrSilencerUpdateRatePhase]),
                   32'(silencerUpdateRatePhase));
        checkEqual({testName, " stepsIntensity"},
                   32'(modelRam[`AddrSilencerCompletionStepsIntensity]),
                   32'(silencerCompletionStepsIntensity));
        checkEqual({testName, " stepsPhase"},
                   32'(modelRam[`AddrSilencerCompletionStepsPhase]),
                   32'(silencerCompletionStepsPhase));
    endtask

    task automatic waitForUpdate(input settingsGroup_t group, input string testName);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < GroupBound && !seen; i++) begin
            @(negedge CLK);
            seen = (group == GroupMod) ? modUpdate : silencerUpdate;
        end
        if (!seen) begin
            errorCount++;
            $display("%s: no update pulse seen within %0d cycles", testName, GroupBound);
        end
    endtask

    // Host may only rewrite the flags once the serviced bits are back to zero.
    task automatic waitFlagsCleared(input regWord_t mask, input string testName);
        regWord_t flags;
        flags = '1;
        for (int i = 0; i < PollLimit && (flags & mask) != '0; i++) begin
            hostRead(`AddrCtlFlag, flags);
        end
        modelRam[`AddrCtlFlag] = modelRam[`AddrCtlFlag] & ~mask;
        checkEqual({testName, " flags"}, 32'(modelRam[`AddrCtlFlag]), 32'(flags));
    endtask

    task automatic runResetTest();
        regWord_t data;
        checkEqual("default reqRdSegment", 32'd0, 32'(modReqRdSegment));
        checkEqual("default cycle0", 32'(`DefaultModCycle), 32'(modCycle0));
        checkEqual("default cycle1", 32'(`DefaultModCycle), 32'(modCycle1));
        checkEqual("default freqDiv0", `DefaultModFreqDiv, modFreqDiv0);
        checkEqual("default freqDiv1", `DefaultModFreqDiv, modFreqDiv1);
        checkEqual("default rep0", `DefaultModRep, modRep0);
        checkEqual("default rep1", `DefaultModRep, modRep1);
        checkEqual("default mode", 32'(`DefaultSilencerMode), 32'(silencerMode));
        checkEqual("default rateIntensity", 32'(`DefaultSilencerUpdateRate),
                   32'(silencerUpdateRateIntensity));
        checkEqual("default ratePhase", 32'(`DefaultSilencerUpdateRate),
                   32'(silencerUpdateRatePhase));
        checkEqual("default stepsIntensity", 32'(`DefaultSilencerCompletionStepsIntensity),
                   32'(silencerCompletionStepsIntensity));
        checkEqual("default stepsPhase", 32'(`DefaultSilencerCompletionStepsPhase),
                   32'(silencerCompletionStepsPhase));
        checkEqual("reset mod pulses", 32'd0, 32'(modPulses));
        checkEqual("reset silencer pulses", 32'd0, 32'(silencerPulses));
        modelRam[`AddrVersionMinor] = {8'h00, `VersionMinor};
        modelRam[`AddrVersionMajor] = {8'h00, `VersionMajor};
        hostRead(`AddrVersionMinor, data);
        checkEqual("version minor", 32'(modelRam[`AddrVersionMinor]), 32'(data));
        hostRead(`AddrVersionMajor, data);
        checkEqual("version major", 32'(modelRam[`AddrVersionMajor]), 32'(data));
        hostWrite(`AddrCtlFlag, 16'd0);
    endtask

    task automatic runGroupTest(input settingsGroup_t group, input string testName);
        int       expectMod;
        int       expectSilencer;
        regWord_t setMask;
        expectMod = modPulses + ((group == GroupMod) ? 1 : 0);
        expectSilencer = silencerPulses + ((group == GroupSilencer) ? 1 : 0);
        writeGroupWords(group);
        if (group == GroupMod) begin
            setMask = 16'd1 << `FlagModSetBit;
        end else begin
            setMask = 16'd1 << `FlagSilencerSetBit;
        end
        hostWrite(`AddrCtlFlag, setMask);
        waitForUpdate(group, testName);
        if (group == GroupMod) begin
            checkModOutputs(testName);
        end else begin
            checkSilencerOutputs(testName);
        end
        waitFlagsCleared(setMask, testName);
        repeat (40) @(negedge CLK);
        checkEqual({testName, " mod pulses"}, 32'(expectMod), 32'(modPulses));
        checkEqual({testName, " silencer pulses"}, 32'(expectSilencer), 32'(silencerPulses));
    endtask

    task automatic runBothTest();
        int       expectMod;
        int       expectSilencer;
        regWord_t setMask;
        expectMod = modPulses + 1;
        expectSilencer = silencerPulses + 1;
        writeGroupWords(GroupMod);
        writeGroupWords(GroupSilencer);
        setMask = (16'd1 << `FlagModSetBit) | (16'd1 << `FlagSilencerSetBit);
        hostWrite(`AddrCtlFlag, setMask);
        waitForUpdate(GroupMod, "both mod");
        checkModOutputs("both mod");
        waitForUpdate(GroupSilencer, "both silencer");
        checkSilencerOutputs("both silencer");
        waitFlagsCleared(setMask, "both");
        repeat (40) @(negedge CLK);
        checkEqual("both mod pulses", 32'(expectMod), 32'(modPulses));
        checkEqual("both silencer pulses", 32'(expectSilencer), 32'(silencerPulses));
        checkEqual("both pulse order", 32'd1, 32'(modOrder < silencerOrder));
    endtask

    task automatic runStateTest();
        regWord_t readback;
        @(negedge CLK);
        thermo = nextLfsrBit();
        modSegment = nextLfsrBit();
        modelRam[`AddrFpgaState] = {14'd0, modSegment, thermo};
        readback = ~modelRam[`AddrFpgaState];
        for (int i = 0; i < PollLimit && readback != modelRam[`AddrFpgaState]; i++) begin
            hostRead(`AddrFpgaState, readback);
        end
        checkEqual("fpga state", 32'(modelRam[`AddrFpgaState]), 32'(readback));
    endtask

    task automatic waitForFan(input logic level);
        for (int i = 0; i < GroupBound && forceFan !== level; i++) begin
            @(negedge CLK);
        end
    endtask

    task automatic runFanTest();
        hostWrite(`AddrCtlFlag, 16'd1 << `FlagForceFanBit);
        waitForFan(1'b1);
        checkEqual("force fan on", 32'd1, 32'(forceFan));
        hostWrite(`AddrCtlFlag, 16'd0);
        waitForFan(1'b0);
        checkEqual("force fan off", 32'd0, 32'(forceFan));
    endtask

    initial begin
        reset = 1'b1;
        hostWe = 1'b0;
        hostAddr = '0;
        hostDin = '0;
        thermo = 1'b0;
        modSegment = 1'b0;
        repeat (5) @(negedge CLK);
        reset = 1'b0;
        repeat (6) @(negedge CLK);
        runResetTest();
        for (int n = 0; n < ModIters; n++) begin
            runGroupTest(GroupMod, "mod group");
        end
        for (int n = 0; n < SilencerIters; n++) begin
            runGroupTest(GroupSilencer, "silencer group");
        end
        for (int n = 0; n < BothIters; n++) begin
            runBothTest();
        end
        for (int n = 0; n < StateIters; n++) begin
            runStateTest();
        end
        runFanTest();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: ctlBridge.sv
`timescale 1ns/1ps

module ctlBridge (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     hostWe,
    input  ctlbridge_pkg::regAddr_t  hostAddr,
    input  ctlbridge_pkg::regWord_t  hostDin,
    output ctlbridge_pkg::regWord_t  hostDout,
    input  logic                     thermo,
    input  logic                     modSegment,
    output logic                     modUpdate,
    output logic                     modReqRdSegment,
    output ctlbridge_pkg::modCycle_t modCycle0,
    output ctlbridge_pkg::modCycle_t modCycle1,
    output ctlbridge_pkg::longWord_t modFreqDiv0,
    output ctlbridge_pkg::longWord_t modFreqDiv1,
    output ctlbridge_pkg::longWord_t modRep0,
    output ctlbridge_pkg::longWord_t modRep1,
    output logic                     silencerUpdate,
    output logic                     silencerMode,
    output ctlbridge_pkg::regWord_t  silencerUpdateRateIntensity,
    output ctlbridge_pkg::regWord_t  silencerUpdateRatePhase,
    output ctlbridge_pkg::regWord_t  silencerCompletionStepsIntensity,
    output ctlbridge_pkg::regWord_t  silencerCompletionStepsPhase,
    output logic                     forceFan
);
    import ctlbridge_pkg::*;

    logic           seqWe;
    regAddr_t       seqAddr;
    regWord_t       seqDin;
    regWord_t       seqDout;
    logic           loadValid;
    settingsGroup_t loadGroup;
    logic [3:0]     loadIndex;
    regWord_t       loadData;
    logic           groupDone;

    ctlRegisterRam i_ctlRegisterRam (.*);

    settingsSequencer i_settingsSequencer (.*);

    settingsRegisters i_settingsRegisters (.*);

endmodule

// File: settingsRegisters.sv
`timescale 1ns/1ps
`include "ctlbridge_defines.svh"

module settingsRegisters (
    input  logic                          CLK,
    input  logic                          reset,
    input  logic                          loadValid,
    input  ctlbridge_pkg::settingsGroup_t loadGroup,
    input  logic [3:0]                    loadIndex,
    input  ctlbridge_pkg::regWord_t       loadData,
    input  logic                          groupDone,
    output logic                          modUpdate,
    output logic                          modReqRdSegment,
    output ctlbridge_pkg::modCycle_t      modCycle0,
    output ctlbridge_pkg::modCycle_t      modCycle1,
    output ctlbridge_pkg::longWord_t      modFreqDiv0,
    output ctlbridge_pkg::longWord_t      modFreqDiv1,
    output ctlbridge_pkg::longWord_t      modRep0,
    output ctlbridge_pkg::longWord_t      modRep1,
    output logic                          silencerUpdate,
    output logic                          silencerMode,
    output ctlbridge_pkg::regWord_t       silencerUpdateRateIntensity,
    output ctlbridge_pkg::regWord_t       silencerUpdateRatePhase,
    output ctlbridge_pkg::regWord_t       silencerCompletionStepsIntensity,
    output ctlbridge_pkg::regWord_t       silencerCompletionStepsPhase
);
    import ctlbridge_pkg::*;

    logic      reqRdSegmentStage;
    modCycle_t cycle0Stage;
    modCycle_t cycle1Stage;
    longWord_t freqDiv0Stage;
    longWord_t freqDiv1Stage;
    longWord_t rep0Stage;
    longWord_t rep1Stage;
    logic      modeStage;
    regWord_t  rateIntensityStage;
    regWord_t  ratePhaseStage;
    regWord_t  stepsIntensityStage;
    regWord_t  stepsPhaseStage;
    logic      commitMod;
    logic      commitSilencer;

    assign commitMod = groupDone && (loadGroup == GroupMod);
    assign commitSilencer = groupDone && (loadGroup == GroupSilencer);

    // Words land in staging by index and cycles keep 15 bits.
    always_ff @(posedge CLK) begin
        if (loadValid && loadGroup == GroupMod) begin
            case (loadIndex)
                4'd0: reqRdSegmentStage <= loadData[0];
                4'd1: cycle0Stage <= loadData[14:0];
                4'd2: freqDiv0Stage[15:0] <= loadData;
                4'd3: freqDiv0Stage[31:16] <= loadData;
                4'd4: cycle1Stage <= loadData[14:0];
                4'd5: freqDiv1Stage[15:0] <= loadData;
                4'd6: freqDiv1Stage[31:16] <= loadData;
                4'd7: rep0Stage[15:0] <= loadData;
                4'd8: rep0Stage[31:16] <= loadData;
                4'd9: rep1Stage[15:0] <= loadData;
                4'd10: rep1Stage[31:16] <= loadData;
                default: ;
            endcase
        end
        if (loadValid && loadGroup == GroupSilencer) begin
            case (loadIndex)
                4'd0: modeStage <= loadData[0];
                4'd1: rateIntensityStage <= loadData;
                4'd2: ratePhaseStage <= loadData;
                4'd3: stepsIntensityStage <= loadData;
                4'd4: stepsPhaseStage <= loadData;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            modUpdate <= 1'b0;
            silencerUpdate <= 1'b0;
            modReqRdSegment <= 1'b0;
            modCycle0 <= `DefaultModCycle;
            modCycle1 <= `DefaultModCycle;
            modFreqDiv0 <= `DefaultModFreqDiv;
            modFreqDiv1 <= `DefaultModFreqDiv;
            modRep0 <= `DefaultModRep;
            modRep1 <= `DefaultModRep;
            silencerMode <= `DefaultSilencerMode;
            silencerUpdateRateIntensity <= `DefaultSilencerUpdateRate;
            silencerUpdateRatePhase <= `DefaultSilencerUpdateRate;
            silencerCompletionStepsIntensity <= `DefaultSilencerCompletionStepsIntensity;
            silencerCompletionStepsPhase <= `DefaultSilencerCompletionStepsPhase;
        end else begin
            modUpdate <= commitMod;
            silencerUpdate <= commitSilencer;
            if (commitMod) begin
                modReqRdSegment <= reqRdSegmentStage;
                modCycle0 <= cycle0Stage;
                modCycle1 <= cycle1Stage;
                modFreqDiv0 <= freqDiv0Stage;
                modFreqDiv1 <= freqDiv1Stage;
                modRep0 <= rep0Stage;
                modRep1 <= rep1Stage;
            end
            if (commitSilencer) begin
                silencerMode <= modeStage;
                silencerUpdateRateIntensity <= rateIntensityStage;
                silencerUpdateRatePhase <= ratePhaseStage;
                silencerCompletionStepsIntensity <= stepsIntensityStage;
                silencerCompletionStepsPhase <= stepsPhaseStage;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (reset) modUpdate |=> !modUpdate)
        else $error("modUpdate longer than one cycle");

    assert property (@(posedge CLK) disable iff (reset) silencerUpdate |=> !silencerUpdate)
        else $error("silencerUpdate longer than one cycle");

endmodule

// File: settingsSequencer.sv
`timescale 1ns/1ps
`include "ctlbridge_defines.svh"

module settingsSequencer (
    input  logic                          CLK,
    input  logic                          reset,
    input  logic                          thermo,
    input  logic                          modSegment,
    output logic                          seqWe,
    output ctlbridge_pkg::regAddr_t       seqAddr,
    output ctlbridge_pkg::regWord_t       seqDin,
    input  ctlbridge_pkg::regWord_t       seqDout,
    output logic                          loadValid,
    output ctlbridge_pkg::settingsGroup_t loadGroup,
    output logic [3:0]                    loadIndex,
    output ctlbridge_pkg::regWord_t       loadData,
    output logic                          groupDone,
    output logic                          forceFan
);
    import ctlbridge_pkg::*;

    localparam int Lat = `RamReadLatency;
    localparam logic [3:0] ModLastIndex = 4'd10;
    localparam logic [3:0] SilencerLastIndex = 4'd4;

    seqState_t      state;
    settingsGroup_t curGroup;
    regWord_t       ctlFlags;
    regWord_t       stateWord;
    logic [3:0]     issueIndex;
    logic [3:0]     lastIndex;
    logic           launchRead;
    logic           launchFlag;
    logic           launchLast;
    logic           flagArrives;

    // Read tags travel alongside the RAM pipeline.
    logic [Lat:0]      pipeValid;
    logic [Lat:0]      pipeFlag;
    logic [Lat:0]      pipeLast;
    logic [Lat:0][3:0] pipeIndex;

    function automatic regAddr_t groupAddr(input settingsGroup_t group, input logic [3:0] index);
        regAddr_t addr;
        if (group == GroupMod) begin
            case (index)
                4'd0: addr = `AddrModReqRdSegment;
                4'd1: addr = `AddrModCycle0;
                4'd2: addr = `AddrModFreqDiv0Lo;
                4'd3: addr = `AddrModFreqDiv0Hi;
                4'd4: addr = `AddrModCycle1;
                4'd5: addr = `AddrModFreqDiv1Lo;
                4'd6: addr = `AddrModFreqDiv1Hi;
                4'd7: addr = `AddrModRep0Lo;
                4'd8: addr = `AddrModRep0Hi;
                4'd9: addr = `AddrModRep1Lo;
                4'd10: addr = `AddrModRep1Hi;
                default: addr = `AddrCtlFlag;
            endcase
        end else begin
            case (index)
                4'd0: addr = `AddrSilencerMode;
                4'd1: addr = `AddrSilencerUpdateRateIntensity;
                4'd2: addr = `AddrSilencerUpdateRatePhase;
                4'd3: addr = `AddrSilencerCompletionStepsIntensity;
                4'd4: addr = `AddrSilencerCompletionStepsPhase;
                default: addr = `AddrCtlFlag;
            endcase
        end
        return addr;
    endfunction

    assign stateWord = {14'd0, modSegment, thermo};
    assign lastIndex = (curGroup == GroupMod) ? ModLastIndex : SilencerLastIndex;
    assign launchRead = (state == StPollRead) || (state == StGroupRead);
    assign launchFlag = (state == StPollRead);
    assign launchLast = (state == StGroupRead) && (issueIndex == lastIndex);
    assign flagArrives = pipeValid[Lat] && pipeFlag[Lat];

    assign loadValid = pipeValid[Lat] && !pipeFlag[Lat];
    assign loadGroup = curGroup;
    assign loadIndex = pipeIndex[Lat];
    assign loadData = seqDout;
    assign forceFan = ctlFlags[`FlagForceFanBit];

    always_ff @(posedge CLK) begin
        if (reset) begin
            pipeValid <= '0;
            groupDone <= 1'b0;
        end else begin
            pipeValid <= {pipeValid[Lat-1:0], launchRead};
            groupDone <= loadValid && pipeLast[Lat];
        end
        pipeFlag <= {pipeFlag[Lat-1:0], launchFlag};
        pipeLast <= {pipeLast[Lat-1:0], launchLast};
        pipeIndex <= {pipeIndex[Lat-1:0], issueIndex};
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= StVerMinor;
            seqWe <= 1'b0;
            seqAddr <= '0;
            seqDin <= '0;
            ctlFlags <= '0;
            curGroup <= GroupMod;
            issueIndex <= '0;
        end else begin
            case (state)
                StVerMinor: begin
                    seqWe <= 1'b1;
                    seqAddr <= `AddrVersionMinor;
                    seqDin <= {8'h00, `VersionMinor};
                    state <= StVerMajor;
                end
                StVerMajor: begin
                    seqAddr <= `AddrVersionMajor;
                    seqDin <= {8'h00, `VersionMajor};
                    state <= StPollRead;
                end
                StPollRead: begin
                    seqWe <= 1'b0;
                    seqAddr <= `AddrCtlFlag;
                    state <= StPollWrite;
                end
                StPollWrite: begin
                    seqWe <= 1'b1;
                    seqAddr <= `AddrFpgaState;
                    seqDin <= stateWord;
                    issueIndex <= '0;
                    // Decide from the stored copy; fresh flags only land when idle.
                    if (ctlFlags[`FlagModSetBit]) begin
                        ctlFlags[`FlagModSetBit] <= 1'b0;
                        curGroup <= GroupMod;
                        state <= StGroupRead;
                    end else if (ctlFlags[`FlagSilencerSetBit]) begin
                        ctlFlags[`FlagSilencerSetBit] <= 1'b0;
                        curGroup <= GroupSilencer;
                        state <= StGroupRead;
                    end else begin
                        if (flagArrives) begin
                            ctlFlags <= seqDout;
                        end
                        state <= StPollRead;
                    end
                end
                StGroupRead: begin
                    seqWe <= 1'b0;
                    seqAddr <= groupAddr(curGroup, issueIndex);
                    issueIndex <= issueIndex + 4'd1;
                    if (issueIndex == lastIndex) begin
                        state <= StWriteFlags;
                    end
                end
                StWriteFlags: begin
                    seqWe <= 1'b1;
                    seqAddr <= `AddrCtlFlag;
                    seqDin <= ctlFlags;
                    state <= StWriteState;
                end
                StWriteState: begin
                    seqAddr <= `AddrFpgaState;
                    seqDin <= stateWord;
                    state <= StPollRead;
                end
                default: begin
                    seqWe <= 1'b0;
                    state <= StPollRead;
                end
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (reset) groupDone |=> !groupDone)
        else $error("groupDone held for more than one cycle");

endmodule

// File: ctlRegisterRam.sv
`timescale 1ns/1ps
`include "ctlbridge_defines.svh"

module ctlRegisterRam (
    input  logic                    CLK,
    input  logic                    hostWe,
    input  ctlbridge_pkg::regAddr_t hostAddr,
    input  ctlbridge_pkg::regWord_t hostDin,
    output ctlbridge_pkg::regWord_t hostDout,
    input  logic                    seqWe,
    input  ctlbridge_pkg::regAddr_t seqAddr,
    input  ctlbridge_pkg::regWord_t seqDin,
    output ctlbridge_pkg::regWord_t seqDout
);
    import ctlbridge_pkg::*;

    regWord_t mem [2**`CtlAddrWidth];
    regAddr_t hostAddrReg;
    regAddr_t seqAddrReg;
    logic     hostCollide;

    // Host write wins on the same address.
    assign hostCollide = hostWe && (hostAddr == seqAddr);

    always_ff @(posedge CLK) begin
        if (seqWe && !hostCollide) begin
            mem[seqAddr] <= seqDin;
        end
        if (hostWe) begin
            mem[hostAddr] <= hostDin;
        end
    end

    // Address register then output register on each port.
    always_ff @(posedge CLK) begin
        hostAddrReg <= hostAddr;
        hostDout <= mem[hostAddrReg];
    end

    always_ff @(posedge CLK) begin
        seqAddrReg <= seqAddr;
        seqDout <= mem[seqAddrReg];
    end

    assert property (@(posedge CLK) hostWe |-> !$isunknown(hostAddr))
        else $error("host write to unknown address");

    assert property (@(posedge CLK) seqWe |-> !$isunknown(seqAddr))
        else $error("sequencer write to unknown address");

endmodule

// File: ctlbridge_pkg.sv
`include "ctlbridge_defines.svh"

package ctlbridge_pkg;

    typedef logic [`CtlAddrWidth-1:0] regAddr_t;
    typedef logic [`CtlDataWidth-1:0] regWord_t;
    typedef logic [31:0] longWord_t;
    typedef logic [14:0] modCycle_t;

    typedef enum logic {
        GroupMod,
        GroupSilencer
    } settingsGroup_t;

    // Sequencer states named by what each launches on the RAM port.
    typedef enum logic [2:0] {
        StVerMinor,
        StVerMajor,
        StPollRead,
        StPollWrite,
        StGroupRead,
        StWriteFlags,
        StWriteState
    } seqState_t;

endpackage

// File: ctlbridge_defines.svh
`ifndef CTLBRIDGE_DEFINES_SVH
`define CTLBRIDGE_DEFINES_SVH

// Control RAM geometry.
`define CtlAddrWidth 8
`define CtlDataWidth 16

`define AddrCtlFlag                          8'h00
`define AddrFpgaState                        8'h01
`define AddrVersionMajor                     8'h30
`define AddrVersionMinor                     8'h31

// Modulation group with halves stored low word first.
`define AddrModReqRdSegment                  8'h20
`define AddrModCycle0                        8'h21
`define AddrModFreqDiv0Lo                    8'h22
`define AddrModFreqDiv0Hi                    8'h23
`define AddrModCycle1                        8'h24
`define AddrModFreqDiv1Lo                    8'h25
`define AddrModFreqDiv1Hi                    8'h26
`define AddrModRep0Lo                        8'h27
`define AddrModRep0Hi                        8'h28
`define AddrModRep1Lo                        8'h29
`define AddrModRep1Hi                        8'h2A

`define AddrSilencerMode                     8'h50
`define AddrSilencerUpdateRateIntensity      8'h51
`define AddrSilencerUpdateRatePhase          8'h52
`define AddrSilencerCompletionStepsIntensity 8'h53
`define AddrSilencerCompletionStepsPhase     8'h54

`define VersionMinor 8'h01
`define VersionMajor 8'h0A

`define FlagModSetBit      0
`define FlagSilencerSetBit 2
`define FlagForceFanBit    13

`define RamReadLatency 2

// Power-up settings.
`define DefaultModCycle                         15'd1
`define DefaultModFreqDiv                       32'd5120
`define DefaultModRep                           32'hFFFFFFFF
`define DefaultSilencerMode                     1'b1
`define DefaultSilencerUpdateRate               16'd256
`define DefaultSilencerCompletionStepsIntensity 16'd10
`define DefaultSilencerCompletionStepsPhase     16'd40

`endif
